// File: include/cc_config.svh
`ifndef CC_CONFIG_SVH
`define CC_CONFIG_SVH

// ==================================================
// Color corrector configuration
// ==================================================

// Bits per color channel.
`define CC_PX_WIDTH    10

// Fraction bits of a coefficient magnitude.
`define CC_FRACT_WIDTH 10

// Cycles from input acceptance to output valid.
// Four MAC stages plus the clip stage.
`define CC_LATENCY     5

`endif

// File: src/cc_pkg.sv
`include "cc_config.svh"

package cc_pkg;

// ==================================================
// Pixel stream types
// ==================================================

typedef logic [`CC_PX_WIDTH - 1 : 0] px_t;

typedef struct packed {
  px_t r;
  px_t g;
  px_t b;
} rgb_t;

// Last marks end of line, user marks start of frame.
typedef struct packed {
  rgb_t pix;
  logic last;
  logic user;
} beat_t;

// ==================================================
// Coefficient types
// ==================================================

localparam int COEF_MAG_WIDTH = `CC_PX_WIDTH + `CC_FRACT_WIDTH;
localparam int NUM_COEFS      = 12;

// Sign-magnitude value, mag scaled by 2**FRACT.
typedef struct packed {
  logic                          sign;
  logic [COEF_MAG_WIDTH - 1 : 0] mag;
} coef_t;

typedef enum logic [3 : 0] {
  SEL_A11, SEL_A12, SEL_A13, SEL_A14,
  SEL_A21, SEL_A22, SEL_A23, SEL_A24,
  SEL_A31, SEL_A32, SEL_A33, SEL_A34
} coef_sel_e;

typedef struct packed {
  coef_sel_e sel;
  coef_t     coef;
} coef_wr_t;

typedef coef_t [NUM_COEFS - 1 : 0] coef_set_t;

localparam int ACC_WIDTH = 2 * COEF_MAG_WIDTH + 2;

typedef logic signed [ACC_WIDTH - 1 : 0] acc_t;

endpackage

// File: src/cc_coef_bank.sv
`include "cc_config.svh"

module cc_coef_bank import cc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      coef_wr_i,
  input  coef_wr_t  coef_wr_data_i,
  input  logic      coef_lock_i,
  output coef_set_t coef_set_o
);

localparam coef_t COEF_ONE = '{
  sign: 1'b0,
  mag:  COEF_MAG_WIDTH'( 1 ) << `CC_FRACT_WIDTH
};

function automatic coef_set_t identity_set();
  coef_set_t set;
  set          = '0;
  set[SEL_A11] = COEF_ONE;
  set[SEL_A22] = COEF_ONE;
  set[SEL_A33] = COEF_ONE;
  return set;
endfunction

localparam coef_set_t IDENTITY_SET = identity_set();

coef_set_t shadow;
coef_set_t shadow_next;
coef_set_t active;

// ==================================================
// Write decode
// ==================================================

always_comb
  begin
    shadow_next = shadow;
    for( int i = 0; i < NUM_COEFS; i++ )
      if( coef_wr_i && ( coef_wr_data_i.sel == coef_sel_e'( i ) ) )
        shadow_next[i] = coef_wr_data_i.coef;
  end

// Lock takes the shadow including a same-cycle write.
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      shadow <= IDENTITY_SET;
      active <= IDENTITY_SET;
    end
  else
    begin
      shadow <= shadow_next;
      if( coef_lock_i )
        active <= shadow_next;
    end

assign coef_set_o = active;

endmodule

// File: src/cc_stage_ctrl.sv
`include "cc_config.svh"

module cc_stage_ctrl (
  input  logic clk_i,
  input  logic rst_i,
  input  logic in_valid_i,
  input  logic in_last_i,
  input  logic in_user_i,
  input  logic out_ready_i,
  output logic advance_o,
  output logic out_valid_o,
  output logic out_last_o,
  output logic out_user_o
);

localparam int LAST_STAGE = `CC_LATENCY - 1;

logic [LAST_STAGE : 0] valid_q;
logic [LAST_STAGE : 0] last_q;
logic [LAST_STAGE : 0] user_q;

// ==================================================
// Stall decision
// ==================================================

// Whole pipeline moves unless a valid output is held.
assign advance_o = !valid_q[LAST_STAGE] || out_ready_i;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    valid_q <= '0;
  else
    if( advance_o )
      valid_q <= { valid_q[LAST_STAGE - 1 : 0], in_valid_i };

// Sideband flags follow their beat.
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      last_q <= '0;
      user_q <= '0;
    end
  else
    if( advance_o )
      begin
        last_q <= { last_q[LAST_STAGE - 1 : 0], in_last_i };
        user_q <= { user_q[LAST_STAGE - 1 : 0], in_user_i };
      end

assign out_valid_o = valid_q[LAST_STAGE];
assign out_last_o  = last_q[LAST_STAGE];
assign out_user_o  = user_q[LAST_STAGE];

endmodule

// File: src/cc_matrix_mac.sv
`include "cc_config.svh"

module cc_matrix_mac import cc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      advance_i,
  input  rgb_t      pix_i,
  input  coef_set_t coef_set_i,
  output acc_t      sum_r_o,
  output acc_t      sum_g_o,
  output acc_t      sum_b_o
);

localparam int ROWS       = 3;
localparam int GAINS      = 3;
localparam int ROW_COEFS  = 4;
localparam int PROD_WIDTH = COEF_MAG_WIDTH + `CC_PX_WIDTH;

typedef logic [PROD_WIDTH - 1 : 0] prod_t;

// Zero-extends the magnitude, then negates on sign.
function automatic acc_t apply_sign(
  input logic  sign_i,
  input prod_t mag_i
);
  acc_t value;
  value = { { ( ACC_WIDTH - PROD_WIDTH ){ 1'b0 } }, mag_i };
  if( sign_i )
    value = -value;
  return value;
endfunction

px_t [GAINS - 1 : 0] chan;

prod_t prod_q [ROWS][GAINS];
acc_t  term_q [ROWS][ROW_COEFS];
acc_t  pair_q [ROWS][2];
acc_t  sum_q  [ROWS];

// Channel order matches column order of a row.
assign chan = { pix_i.b, pix_i.g, pix_i.r };

// ==================================================
// Stage 1: unsigned products
// ==================================================

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    prod_q <= '{ default: '0 };
  else
    if( advance_i )
      for( int row = 0; row < ROWS; row++ )
        for( int col = 0; col < GAINS; col++ )
          prod_q[row][col] <= coef_set_i[row * ROW_COEFS + col].mag * chan[col];

// ==================================================
// Stage 2: sign conversion
// ==================================================

// Offset is taken in units of 2**-FRACT.
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    term_q <= '{ default: '0 };
  else
    if( advance_i )
      for( int row = 0; row < ROWS; row++ )
        begin
          for( int col = 0; col < GAINS; col++ )
            term_q[row][col] <= apply_sign( coef_set_i[row * ROW_COEFS + col].sign,
                                            prod_q[row][col] );
          term_q[row][GAINS] <= apply_sign( coef_set_i[row * ROW_COEFS + GAINS].sign,
                                            prod_t'( coef_set_i[row * ROW_COEFS + GAINS].mag ) );
        end

// ==================================================
// Stage 3 and 4: adder tree
// ==================================================

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    pair_q <= '{ default: '0 };
  else
    if( advance_i )
      for( int row = 0; row < ROWS; row++ )
        begin
          pair_q[row][0] <= term_q[row][0] + term_q[row][1];
          pair_q[row][1] <= term_q[row][2] + term_q[row][3];
        end

// Totals stay scaled by 2**FRACT.
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    sum_q <= '{ default: '0 };
  else
    if( advance_i )
      for( int row = 0; row < ROWS; row++ )
        sum_q[row] <= pair_q[row][0] + pair_q[row][1];

assign sum_r_o = sum_q[0];
assign sum_g_o = sum_q[1];
assign sum_b_o = sum_q[2];

endmodule

// File: src/cc_clip_pack.sv
`include "cc_config.svh"

module cc_clip_pack import cc_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  input  logic advance_i,
  input  acc_t sum_r_i,
  input  acc_t sum_g_i,
  input  acc_t sum_b_i,
  output rgb_t pix_o
);

// Floor by arithmetic shift, then saturate.
function automatic px_t clip( input acc_t sum_i );
  acc_t shifted;
  px_t  result;
  shifted = sum_i >>> `CC_FRACT_WIDTH;
  if( shifted[ACC_WIDTH - 1] )
    result = '0;
  else
    if( |shifted[ACC_WIDTH - 2 : `CC_PX_WIDTH] )
      result = '1;
    else
      result = shifted[`CC_PX_WIDTH - 1 : 0];
  return result;
endfunction

rgb_t pix_q;

// ==================================================
// Output register
// ==================================================

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    pix_q <= '0;
  else
    if( advance_i )
      begin
        pix_q.r <= clip( sum_r_i );
        pix_q.g <= clip( sum_g_i );
        pix_q.b <= clip( sum_b_i );
      end

assign pix_o = pix_q;

endmodule

// File: src/color_corrector.sv
`include "cc_config.svh"

module color_corrector import cc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     in_valid_i,
  input  beat_t    in_beat_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output beat_t    out_beat_o,
  input  logic     out_ready_i,
  input  logic     coef_wr_i,
  input  coef_wr_t coef_wr_data_i,
  input  logic     coef_lock_i
);

coef_set_t coef_set;
logic      advance;
logic      out_last;
logic      out_user;
acc_t      sum_r;
acc_t      sum_g;
acc_t      sum_b;
rgb_t      out_pix;

cc_coef_bank coef_bank (
  .clk_i          ( clk_i          ),
  .rst_i          ( rst_i          ),
  .coef_wr_i      ( coef_wr_i      ),
  .coef_wr_data_i ( coef_wr_data_i ),
  .coef_lock_i    ( coef_lock_i    ),
  .coef_set_o     ( coef_set       )
);

cc_stage_ctrl stage_ctrl (
  .clk_i       ( clk_i           ),
  .rst_i       ( rst_i           ),
  .in_valid_i  ( in_valid_i      ),
  .in_last_i   ( in_beat_i.last  ),
  .in_user_i   ( in_beat_i.user  ),
  .out_ready_i ( out_ready_i     ),
  .advance_o   ( advance         ),
  .out_valid_o ( out_valid_o     ),
  .out_last_o  ( out_last        ),
  .out_user_o  ( out_user        )
);

cc_matrix_mac matrix_mac (
  .clk_i      ( clk_i         ),
  .rst_i      ( rst_i         ),
  .advance_i  ( advance       ),
  .pix_i      ( in_beat_i.pix ),
  .coef_set_i ( coef_set      ),
  .sum_r_o    ( sum_r         ),
  .sum_g_o    ( sum_g         ),
  .sum_b_o    ( sum_b         )
);

cc_clip_pack clip_pack (
  .clk_i     ( clk_i   ),
  .rst_i     ( rst_i   ),
  .advance_i ( advance ),
  .sum_r_i   ( sum_r   ),
  .sum_g_i   ( sum_g   ),
  .sum_b_i   ( sum_b   ),
  .pix_o     ( out_pix )
);

assign in_ready_o = advance;
assign out_beat_o = '{ pix: out_pix, last: out_last, user: out_user };

endmodule

// File: tests/tb_color_corrector.sv
`include "cc_config.svh"

module tb_color_corrector import cc_pkg::*; ();

localparam int     NUM_BEATS      = 60 + 8 * 40 + 40 + 200 + 60 + 80;
localparam int     TIMEOUT_CYCLES = NUM_BEATS * 4 + 200;
localparam longint PX_MAX         = ( longint'( 1 ) << `CC_PX_WIDTH ) - 1;

logic     clk_i;
logic     rst_i;
logic     in_valid_i;
beat_t    in_beat_i;
logic     in_ready_o;
logic     out_valid_o;
beat_t    out_beat_o;
logic     out_ready_i;
logic     coef_wr_i;
coef_wr_t coef_wr_data_i;
logic     coef_lock_i;

integer seed;
integer ready_seed;
int     cycle_count;
int     pass_count;
int     error_count;
bit     check_latency;
bit     ready_random;
logic   held_valid;
beat_t  held_beat;

coef_t shadow_m [NUM_COEFS];
coef_t active_m [NUM_COEFS];
beat_t exp_q [$];
int    acc_cycle_q [$];

color_corrector i_dut (
  .clk_i          ( clk_i          ),
  .rst_i          ( rst_i          ),
  .in_valid_i     ( in_valid_i     ),
  .in_beat_i      ( in_beat_i      ),
  .in_ready_o     ( in_ready_o     ),
  .out_valid_o    ( out_valid_o    ),
  .out_beat_o     ( out_beat_o     ),
  .out_ready_i    ( out_ready_i    ),
  .coef_wr_i      ( coef_wr_i      ),
  .coef_wr_data_i ( coef_wr_data_i ),
  .coef_lock_i    ( coef_lock_i    )
);

always #5 clk_i = ~clk_i;

// ==================================================
// Reference model
// ==================================================

function automatic longint coef_value( input coef_t c );
  longint v;
  v = longint'( c.mag );
  if( c.sign )
    v = -v;
  return v;
endfunction

// Offset is in units of 2**-FRACT, gains scale the channels.
function automatic px_t model_channel( input int row, input rgb_t pix );
  longint acc;
  longint chan [3];
  chan[0] = longint'( pix.r );
  chan[1] = longint'( pix.g );
  chan[2] = longint'( pix.b );
  acc     = coef_value( active_m[row * 4 + 3] );
  for( int col = 0; col < 3; col++ )
    acc += coef_value( active_m[row * 4 + col] ) * chan[col];
  acc = acc >>> `CC_FRACT_WIDTH;
  if( acc < 0 )
    acc = 0;
  else
    if( acc > PX_MAX )
      acc = PX_MAX;
  return px_t'( acc );
endfunction

function automatic beat_t model_beat( input beat_t b );
  beat_t result;
  result.pix.r = model_channel( 0, b.pix );
  result.pix.g = model_channel( 1, b.pix );
  result.pix.b = model_channel( 2, b.pix );
  result.last  = b.last;
  result.user  = b.user;
  return result;
endfunction

task automatic check_value( input string name, input logic [63 : 0] actual,
                            input logic [63 : 0] expected );
  if( actual !== expected )
    begin
      $display( "** Error: %s = %0h, expected %0h", name, actual, expected );
      error_count++;
    end
  else
    pass_count++;
endtask

// ==================================================
// Scoreboard and timeout
// ==================================================

always @( posedge clk_i )
  begin
    beat_t exp_beat;
    int    acc_cycle;
    cycle_count++;
    if( cycle_count >= TIMEOUT_CYCLES )
      begin
        $display( "Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES );
        $display( "Simulation FAILED" );
        $finish;
      end
    else
      if( !rst_i )
        begin
          if( coef_wr_i )
            shadow_m[coef_wr_data_i.sel] = coef_wr_data_i.coef;
          if( coef_lock_i )
            active_m = shadow_m;
          // A stalled output must hold still.
          if( held_valid )
            begin
              check_value( "out_valid_o", out_valid_o, 1'b1 );
              check_value( "out_beat_o", out_beat_o, held_beat );
            end
          // Input side freezes together with a held output.
          check_value( "in_ready_o", in_ready_o, !( out_valid_o && !out_ready_i ) );
          if( out_valid_o && out_ready_i )
            if( exp_q.size() == 0 )
              begin
                $display( "Error: output beat arrived when no beat was expected" );
                error_count++;
              end
            else
              begin
                exp_beat  = exp_q.pop_front();
                acc_cycle = acc_cycle_q.pop_front();
                check_value( "out_beat_o.pix.r", out_beat_o.pix.r, exp_beat.pix.r );
                check_value( "out_beat_o.pix.g", out_beat_o.pix.g, exp_beat.pix.g );
                check_value( "out_beat_o.pix.b", out_beat_o.pix.b, exp_beat.pix.b );
                check_value( "out_beat_o.last", out_beat_o.last, exp_beat.last );
                check_value( "out_beat_o.user", out_beat_o.user, exp_beat.user );
                if( check_latency )
                  check_value( "latency", cycle_count - acc_cycle, `CC_LATENCY );
              end
          if( in_valid_i && in_ready_o )
            begin
              exp_q.push_back( model_beat( in_beat_i ) );
              acc_cycle_q.push_back( cycle_count );
            end
          held_valid = out_valid_o && !out_ready_i;
          held_beat  = out_beat_o;
        end
  end

// Sink readiness.
always @( posedge clk_i )
  begin
    #1;
    if( ready_random )
      out_ready_i = 1'( $random( ready_seed ) );
    else
      out_ready_i = 1'b1;
  end

// ==================================================
// Stimulus
// ==================================================

task automatic next_cycle();
  @( posedge clk_i );
  #1;
endtask

task automatic send_beat( input int max_gap );
  beat_t b;
  int    gap;
  gap = ( max_gap > 0 ) ? int'( $unsigned( $random( seed ) ) % ( max_gap + 1 ) ) : 0;
  repeat( gap )
    next_cycle();
  b.pix.r    = px_t'( $random( seed ) );
  b.pix.g    = px_t'( $random( seed ) );
  b.pix.b    = px_t'( $random( seed ) );
  b.last     = 1'( $random( seed ) );
  b.user     = 1'( $random( seed ) );
  in_beat_i  = b;
  in_valid_i = 1'b1;
  do
    @( posedge clk_i );
  while( !in_ready_o );
  #1;
  in_valid_i = 1'b0;
endtask

task automatic send_beats( input int count, input int max_gap );
  repeat( count )
    send_beat( max_gap );
endtask

task automatic wait_drained();
  do
    next_cycle();
  while( exp_q.size() != 0 );
endtask

task automatic write_coef( input coef_sel_e sel, input coef_t c, input bit lock );
  coef_wr_i           = 1'b1;
  coef_wr_data_i.sel  = sel;
  coef_wr_data_i.coef = c;
  coef_lock_i         = lock;
  next_cycle();
  coef_wr_i   = 1'b0;
  coef_lock_i = 1'b0;
endtask

task automatic lock_coefs();
  coef_lock_i = 1'b1;
  next_cycle();
  coef_lock_i = 1'b0;
endtask

function automatic coef_t random_coef( input int mag_bits );
  coef_t c;
  c.sign = 1'( $random( seed ) );
  c.mag  = COEF_MAG_WIDTH'( $unsigned( $random( seed ) ) % ( 32'd1 << mag_bits ) );
  return c;
endfunction

// Gains up to 4.0, offsets up to 256; lock rides on the last write.
task automatic write_random_matrix( input bit lock );
  for( int i = 0; i < NUM_COEFS; i++ )
    write_coef( coef_sel_e'( i ), random_coef( ( i % 4 == 3 ) ? 18 : 12 ),
                lock && ( i == NUM_COEFS - 1 ) );
endtask

task automatic report_test( input string name );
  $display( "Test %s finished, %0d errors so far", name, error_count );
endtask

initial
  begin
    seed           = 32'h2cf3ae36;
    ready_seed     = $random( seed );
    clk_i          = 1'b0;
    rst_i          = 1'b1;
    in_valid_i     = 1'b0;
    in_beat_i      = '0;
    out_ready_i    = 1'b1;
    coef_wr_i      = 1'b0;
    coef_wr_data_i = '0;
    coef_lock_i    = 1'b0;
    held_valid     = 1'b0;
    held_beat      = '0;
    check_latency  = 1'b0;
    ready_random   = 1'b0;
    for( int i = 0; i < NUM_COEFS; i++ )
      active_m[i] = '0;
    active_m[0].mag  = COEF_MAG_WIDTH'( 1 ) << `CC_FRACT_WIDTH;
    active_m[5].mag  = COEF_MAG_WIDTH'( 1 ) << `CC_FRACT_WIDTH;
    active_m[10].mag = COEF_MAG_WIDTH'( 1 ) << `CC_FRACT_WIDTH;
    shadow_m         = active_m;
    repeat( 4 )
      @( posedge clk_i );
    #1;
    rst_i = 1'b0;

    check_latency = 1'b1;
    send_beats( 60, 2 );
    wait_drained();
    check_latency = 1'b0;
    report_test( "identity" );

    repeat( 8 )
      begin
        write_random_matrix( 1'b1 );
        send_beats( 40, 1 );
        wait_drained();
      end
    report_test( "random_matrix" );

    // Red saturates high, green and blue are pulled to zero.
    for( int i = 0; i < 4; i++ )
      write_coef( coef_sel_e'( i ), '{ sign: 1'b0, mag: '1 }, 1'b0 );
    for( int i = 4; i < 7; i++ )
      write_coef( coef_sel_e'( i ), '0, 1'b0 );
    write_coef( SEL_A24, '{ sign: 1'b1, mag: '1 }, 1'b0 );
    for( int i = 8; i < 11; i++ )
      write_coef( coef_sel_e'( i ), '{ sign: 1'b1, mag: 20'h80000 }, 1'b0 );
    write_coef( SEL_A34, '{ sign: 1'b1, mag: 20'h40000 }, 1'b1 );
    send_beats( 40, 1 );
    wait_drained();
    report_test( "saturation" );

    write_random_matrix( 1'b1 );
    ready_random = 1'b1;
    send_beats( 200, 3 );
    wait_drained();
    ready_random = 1'b0;
    report_test( "back_pressure" );

    write_random_matrix( 1'b0 );
    send_beats( 30, 1 );
    wait_drained();
    lock_coefs();
    send_beats( 30, 1 );
    wait_drained();
    report_test( "shadow_without_lock" );

    ready_random = 1'b1;
    send_beats( 80, 2 );
    wait_drained();
    ready_random = 1'b0;
    report_test( "sideband" );

    $display( "Checks passed: %0d, errors: %0d", pass_count, error_count );
    if( error_count == 0 )
      $display( "Simulation PASSED" );
    else
      $display( "Simulation FAILED" );
    $finish;
  end

endmodule

// File: color_corrector.f
+incdir+include
src/cc_pkg.sv
src/cc_coef_bank.sv
src/cc_stage_ctrl.sv
src/cc_matrix_mac.sv
src/cc_clip_pack.sv
src/color_corrector.sv
tests/tb_color_corrector.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary -Wno-fatal
TOP       = tb_color_corrector
FILELIST  = color_corrector.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)
